//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module mcpuTb -o mcpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mcpuSim > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi

if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

exit 0

//--- sim.f
+incdir+source
source/mcpuPkg.sv
source/regFile.sv
source/alu.sv
source/multiCycleDatapath.sv
source/multiCycleControl.sv
source/mcpuTop.sv
tests/mcpuTb.sv

//--- source/alu.sv
`timescale 1ns/1ns
`include "mcpuConsts.svh"

module alu (
    input  logic [`MCPU_XLEN-1:0] a,
    input  logic [`MCPU_XLEN-1:0] b,
    input  mcpuPkg::aluOpT        op,
    output logic [`MCPU_XLEN-1:0] res,
    output logic                  zero,
    output logic                  overflow
);

    localparam int Msb = `MCPU_XLEN - 1;

    logic [`MCPU_XLEN-1:0] sum;
    logic [`MCPU_XLEN-1:0] diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (op)
            mcpuPkg::aluAnd: res = a & b;
            mcpuPkg::aluOr:  res = a | b;
            mcpuPkg::aluAdd: res = sum;
            mcpuPkg::aluSub: res = diff;
            mcpuPkg::aluSlt: res = {{(`MCPU_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default:         res = '0;
        endcase
    end

    assign zero = (res == '0);

    // Signed overflow, same-sign operands giving a result of the other sign
    always_comb begin
        case (op)
            mcpuPkg::aluAdd: overflow = (a[Msb] == b[Msb]) && (sum[Msb] != a[Msb]);
            mcpuPkg::aluSub: overflow = (a[Msb] != b[Msb]) && (diff[Msb] != a[Msb]);
            default:         overflow = 1'b0;
        endcase
    end

endmodule

//--- source/mcpuConsts.svh
`ifndef MCPU_CONSTS_SVH
`define MCPU_CONSTS_SVH

// Core widths and start address
`define MCPU_XLEN      32
`define MCPU_NREGS     32
`define MCPU_RESET_PC  32'h0000_0000

// Primary opcodes
`define OP_RTYPE  6'h00
`define OP_J      6'h02
`define OP_JAL    6'h03
`define OP_BEQ    6'h04
`define OP_BNE    6'h05
`define OP_ADDI   6'h08
`define OP_ORI    6'h0d
`define OP_LW     6'h23
`define OP_SW     6'h2b

// Funct field of R-type
`define FN_ADD  6'h20
`define FN_SUB  6'h22
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_SLT  6'h2a

`endif

//--- source/mcpuPkg.sv
package mcpuPkg;

    // ALU operation codes
    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111
    } aluOpT;

    // Datapath control bundle driven by the FSM
    typedef struct packed {
        logic       iorD;          // 1: PC addresses memory
        logic       irWrite;
        logic [1:0] regDst;        // rt, rd, r31
        logic       regWrite;
        logic [1:0] memToReg;      // ALUOut, MDR, PC
        logic       aluSrcA;       // 0: PC, 1: A
        logic [1:0] aluSrcB;       // B, four, imm, imm << 2
        aluOpT      aluOp;
        logic [1:0] pcSource;      // ALU result, ALUOut, jump target
        logic       pcWrite;
        logic       pcWriteCond;
        logic       branchOnZero;  // 1 for beq, 0 for bne
    } ctrlT;

    // Low half of an instruction, R-type fields or immediate
    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    typedef union packed {
        rFieldsT     r;
        logic [15:0] imm;
    } lowFieldsT;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        lowFieldsT  low;
    } instFieldsT;

endpackage

//--- source/mcpuTop.sv
`timescale 1ns/1ns
`include "mcpuConsts.svh"

module mcpuTop (
    input  logic                  clk,
    input  logic                  rstN,
    output logic [`MCPU_XLEN-1:0] memAddr,
    output logic [`MCPU_XLEN-1:0] memWData,
    output logic                  memRead,
    output logic                  memWrite,
    input  logic [`MCPU_XLEN-1:0] memRData,
    input  logic                  memReady
);

    mcpuPkg::ctrlT       ctrl;
    mcpuPkg::instFieldsT inst;

    multiCycleControl u_control (
        .clk      (clk),
        .rstN     (rstN),
        .inst     (inst),
        .memReady (memReady),
        .ctrl     (ctrl),
        .memRead  (memRead),
        .memWrite (memWrite)
    );

    multiCycleDatapath u_datapath (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .inst     (inst),
        .memRData (memRData),
        .memReady (memReady),
        .memAddr  (memAddr),
        .memWData (memWData)
    );

endmodule

//--- source/multiCycleControl.sv
`timescale 1ns/1ns
`include "mcpuConsts.svh"

module multiCycleControl (
    input  logic                clk,
    input  logic                rstN,
    input  mcpuPkg::instFieldsT inst,
    input  logic                memReady,
    output mcpuPkg::ctrlT       ctrl,
    output logic                memRead,
    output logic                memWrite
);

    typedef enum logic [3:0] {
        stFetch,
        stDecode,
        stMemAddr,
        stMemRead,
        stMemWriteBack,
        stMemWrite,
        stExecute,
        stImmExecute,
        stAluWriteBack,
        stBranch,
        stJump
    } stateT;

    stateT state;
    stateT stateNext;
    logic  active;   // low until the first edge after reset

    function automatic mcpuPkg::aluOpT functOp(input logic [5:0] funct);
        mcpuPkg::aluOpT op;
        case (funct)
            `FN_SUB: op = mcpuPkg::aluSub;
            `FN_AND: op = mcpuPkg::aluAnd;
            `FN_OR:  op = mcpuPkg::aluOr;
            `FN_SLT: op = mcpuPkg::aluSlt;
            default: op = mcpuPkg::aluAdd;
        endcase
        return op;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= stFetch;
            active <= 1'b0;
        end else begin
            active <= 1'b1;
            if (active) begin
                state <= stateNext;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next state

    always_comb begin
        stateNext = state;
        case (state)
            stFetch: begin
                if (memReady) begin
                    stateNext = stDecode;
                end
            end
            stDecode: begin
                case (inst.opcode)
                    `OP_RTYPE:         stateNext = stExecute;
                    `OP_ADDI, `OP_ORI: stateNext = stImmExecute;
                    `OP_LW, `OP_SW:    stateNext = stMemAddr;
                    `OP_BEQ, `OP_BNE:  stateNext = stBranch;
                    `OP_J, `OP_JAL:    stateNext = stJump;
                    default:           stateNext = stFetch;
                endcase
            end
            stMemAddr: begin
                stateNext = (inst.opcode == `OP_LW) ? stMemRead : stMemWrite;
            end
            stMemRead: begin
                if (memReady) begin
                    stateNext = stMemWriteBack;
                end
            end
            stMemWrite: begin
                if (memReady) begin
                    stateNext = stFetch;
                end
            end
            stExecute, stImmExecute: stateNext = stAluWriteBack;
            default: stateNext = stFetch;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Control outputs

    always_comb begin
        ctrl     = '0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        if (active) begin
            case (state)
                stFetch: begin
                    memRead           = 1'b1;
                    ctrl.iorD         = 1'b1;
                    ctrl.irWrite      = 1'b1;
                    ctrl.aluSrcB      = 2'b01;
                    ctrl.aluOp        = mcpuPkg::aluAdd;
                    ctrl.pcWrite      = memReady;   // PC+4 only once the word arrives
                end
                stDecode: begin
                    // Branch target into ALUOut
                    ctrl.aluSrcB      = 2'b11;
                    ctrl.aluOp        = mcpuPkg::aluAdd;
                end
                stMemAddr, stMemRead, stMemWrite: begin
                    // ALU keeps computing the address so ALUOut holds while waiting
                    ctrl.aluSrcA      = 1'b1;
                    ctrl.aluSrcB      = 2'b10;
                    ctrl.aluOp        = mcpuPkg::aluAdd;
                    memRead           = (state == stMemRead);
                    memWrite          = (state == stMemWrite);
                end
                stMemWriteBack: begin
                    ctrl.regWrite     = 1'b1;
                    ctrl.memToReg     = 2'b01;
                end
                stExecute: begin
                    ctrl.aluSrcA      = 1'b1;
                    ctrl.aluOp        = functOp(inst.low.r.funct);
                end
                stImmExecute: begin
                    ctrl.aluSrcA      = 1'b1;
                    ctrl.aluSrcB      = 2'b10;
                    ctrl.aluOp        = (inst.opcode == `OP_ORI) ? mcpuPkg::aluOr
                                                                 : mcpuPkg::aluAdd;
                end
                stAluWriteBack: begin
                    ctrl.regWrite     = 1'b1;
                    ctrl.regDst       = (inst.opcode == `OP_RTYPE) ? 2'b01 : 2'b00;
                end
                stBranch: begin
                    ctrl.aluSrcA      = 1'b1;
                    ctrl.aluOp        = mcpuPkg::aluSub;
                    ctrl.pcSource     = 2'b01;
                    ctrl.pcWriteCond  = 1'b1;
                    ctrl.branchOnZero = (inst.opcode == `OP_BEQ);
                end
                stJump: begin
                    ctrl.pcSource     = 2'b10;
                    ctrl.pcWrite      = 1'b1;
                    if (inst.opcode == `OP_JAL) begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 2'b10;
                        ctrl.memToReg = 2'b10;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- source/multiCycleDatapath.sv
`timescale 1ns/1ns
`include "mcpuConsts.svh"

module multiCycleDatapath (
    input  logic                  clk,
    input  logic                  rstN,
    input  mcpuPkg::ctrlT         ctrl,
    output mcpuPkg::instFieldsT   inst,
    input  logic [`MCPU_XLEN-1:0] memRData,
    input  logic                  memReady,
    output logic [`MCPU_XLEN-1:0] memAddr,
    output logic [`MCPU_XLEN-1:0] memWData
);

    logic [`MCPU_XLEN-1:0] pc;
    logic [`MCPU_XLEN-1:0] mdr;
    logic [`MCPU_XLEN-1:0] regA;
    logic [`MCPU_XLEN-1:0] regB;
    logic [`MCPU_XLEN-1:0] aluOut;
    logic [`MCPU_XLEN-1:0] rdDataA;
    logic [`MCPU_XLEN-1:0] rdDataB;
    logic [`MCPU_XLEN-1:0] immExt;
    logic [`MCPU_XLEN-1:0] aluA;
    logic [`MCPU_XLEN-1:0] aluB;
    logic [`MCPU_XLEN-1:0] aluRes;
    logic [`MCPU_XLEN-1:0] wrData;
    logic [`MCPU_XLEN-1:0] pcNext;
    logic [`MCPU_XLEN-1:0] jumpTarget;
    logic [4:0]            wrAddr;
    logic                  aluZero;
    logic                  pcLoad;

    //////////////////////////////////////////////////////////////////////
    // State registers

    assign pcLoad = ctrl.pcWrite || (ctrl.pcWriteCond && (aluZero == ctrl.branchOnZero));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc   <= `MCPU_RESET_PC;
            inst <= '0;
        end else begin
            if (pcLoad) begin
                pc <= pcNext;
            end
            if (ctrl.irWrite && memReady) begin
                inst <= memRData;
            end
        end
    end

    // Operand and result latches refresh every cycle
    always_ff @(posedge clk) begin
        regA   <= rdDataA;
        regB   <= rdDataB;
        aluOut <= aluRes;
        if (memReady) begin
            mdr <= memRData;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register file and write-back selection

    always_comb begin
        case (ctrl.regDst)
            2'b01:   wrAddr = inst.low.r.rd;
            2'b10:   wrAddr = 5'd31;
            default: wrAddr = inst.rt;
        endcase
        case (ctrl.memToReg)
            2'b01:   wrData = mdr;
            2'b10:   wrData = pc;     // already PC+4 when jal links
            default: wrData = aluOut;
        endcase
    end

    regFile u_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (inst.rs),
        .rdAddrB (inst.rt),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .wrEn    (ctrl.regWrite),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    //////////////////////////////////////////////////////////////////////
    // ALU operands

    // ori takes a zero-extended immediate
    assign immExt = (inst.opcode == `OP_ORI) ?
                    {{(`MCPU_XLEN-16){1'b0}}, inst.low.imm} :
                    {{(`MCPU_XLEN-16){inst.low.imm[15]}}, inst.low.imm};

    assign aluA = ctrl.aluSrcA ? regA : pc;

    always_comb begin
        case (ctrl.aluSrcB)
            2'b00:   aluB = regB;
            2'b01:   aluB = `MCPU_XLEN'd4;
            2'b10:   aluB = immExt;
            default: aluB = {immExt[`MCPU_XLEN-3:0], 2'b00};
        endcase
    end

    // Overflow is flagged only, never trapped
    alu u_alu (
        .a        (aluA),
        .b        (aluB),
        .op       (ctrl.aluOp),
        .res      (aluRes),
        .zero     (aluZero),
        .overflow ()
    );

    // Next PC and memory port
    assign jumpTarget = {pc[`MCPU_XLEN-1 -: 4], inst.rs, inst.rt, inst.low.imm, 2'b00};

    always_comb begin
        case (ctrl.pcSource)
            2'b00:   pcNext = aluRes;
            2'b10:   pcNext = jumpTarget;
            default: pcNext = aluOut;
        endcase
    end

    assign memAddr  = ctrl.iorD ? pc : aluOut;
    assign memWData = regB;

endmodule

//--- source/regFile.sv
`timescale 1ns/1ns
`include "mcpuConsts.svh"

module regFile (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [4:0]            rdAddrA,
    input  logic [4:0]            rdAddrB,
    input  logic [4:0]            wrAddr,
    input  logic [`MCPU_XLEN-1:0] wrData,
    input  logic                  wrEn,
    output logic [`MCPU_XLEN-1:0] rdDataA,
    output logic [`MCPU_XLEN-1:0] rdDataB
);

    // Register 0 has no storage
    logic [`MCPU_XLEN-1:0] regs [1:`MCPU_NREGS-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `MCPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Asynchronous read ports
    assign rdDataA = (rdAddrA == 5'd0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == 5'd0) ? '0 : regs[rdAddrB];

endmodule

//--- tests/mcpuTb.sv
`timescale 1ns/1ns
`include "mcpuConsts.svh"

module mcpuTb;

    localparam int ProgLen   = 60;
    localparam int TimeoutNs = ProgLen * (5 + 4 * 3) * 8 + 2000;
    localparam logic [`MCPU_XLEN-1:0] EndPc = `MCPU_RESET_PC + 32'((ProgLen - 1) * 4);

    // One memory access as the ISA model expects it
    typedef struct packed {
        logic                  isWrite;
        logic [`MCPU_XLEN-1:0] addr;
        logic [`MCPU_XLEN-1:0] data;
    } accessT;

    logic                  clk;
    logic                  rstN;
    logic [`MCPU_XLEN-1:0] memAddr;
    logic [`MCPU_XLEN-1:0] memWData;
    logic                  memRead;
    logic                  memWrite;
    logic [`MCPU_XLEN-1:0] memRData;
    logic                  memReady;

    logic [`MCPU_XLEN-1:0] mem [0:255];
    logic [`MCPU_XLEN-1:0] modelMem [0:255];
    accessT                expected [$];
    logic [31:0]           rngState;
    logic                  finished;

    mcpuTop u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memRData (memRData),
        .memReady (memReady)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Random numbers and failure handling

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] drawRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // Few registers so results feed each other, r31 for links
    function automatic logic [4:0] pickReg();
        logic [31:0] r;
        r = drawRandom();
        return (r[2:0] == 3'd7) ? 5'd31 : {2'b00, r[2:0]};
    endfunction

    function automatic accessT makeAccess(input logic isWrite,
                                          input logic [`MCPU_XLEN-1:0] addr,
                                          input logic [`MCPU_XLEN-1:0] data);
        accessT acc;
        acc.isWrite = isWrite;
        acc.addr    = addr;
        acc.data    = data;
        return acc;
    endfunction

    task automatic stopWithFailure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkAddr(input logic [`MCPU_XLEN-1:0] got,
                             input logic [`MCPU_XLEN-1:0] want, input string what);
        if (got !== want) begin
            stopWithFailure($sformatf("Mismatch at %0t: %s address %h, expected %h",
                                      $time, what, got, want));
        end
    endtask

    task automatic checkStore(input logic [`MCPU_XLEN-1:0] gotAddr,
                              input logic [`MCPU_XLEN-1:0] gotData,
                              input logic [`MCPU_XLEN-1:0] wantAddr,
                              input logic [`MCPU_XLEN-1:0] wantData);
        if ((gotAddr !== wantAddr) || (gotData !== wantData)) begin
            stopWithFailure($sformatf("Mismatch at %0t: store %h to %h, expected %h to %h",
                                      $time, gotData, gotAddr, wantData, wantAddr));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program generator and ISA model

    task automatic buildProgram();
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [5:0]  fn;
        logic [15:0] dataOff;
        int          target;
        for (int i = 0; i < 256; i++) begin
            mem[i] = i * 32'h9E37_79B9;
        end
        for (int i = 0; i < ProgLen - 1; i++) begin
            r  = drawRandom();
            rs = pickReg();
            rt = pickReg();
            rd = pickReg();
            // Forward only, one to four words ahead
            target = i + 1 + int'(r[9:8]);
            if (target > ProgLen - 1) begin
                target = ProgLen - 1;
            end
            // Data region at 0x300
            dataOff = {8'h03, r[15:10], 2'b00};
            case (r[6:4])
                3'd0, 3'd5: fn = `FN_ADD;
                3'd1, 3'd6: fn = `FN_SUB;
                3'd2:       fn = `FN_AND;
                3'd3:       fn = `FN_OR;
                default:    fn = `FN_SLT;
            endcase
            case (r[3:0])
                4'd0, 4'd1, 4'd2, 4'd3: mem[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
                4'd4, 4'd5:             mem[i] = {`OP_ADDI, rs, rt, r[31:16]};
                4'd6:                   mem[i] = {`OP_ORI, rs, rt, r[31:16]};
                4'd7, 4'd8:             mem[i] = {`OP_LW, 5'd0, rt, dataOff};
                4'd9, 4'd10, 4'd11:     mem[i] = {`OP_SW, 5'd0, rt, dataOff};
                4'd12:   mem[i] = {`OP_BEQ, rs, rt, 16'(target - i - 1)};
                4'd13:   mem[i] = {`OP_BNE, rs, rt, 16'(target - i - 1)};
                4'd14:   mem[i] = {`OP_J, 26'(target)};
                default: mem[i] = {`OP_JAL, 26'(target)};
            endcase
        end
        mem[ProgLen - 1] = {`OP_J, 26'(ProgLen - 1)};
    endtask

    // Fills the expected access list, ends after the jump-to-self runs once
    task automatic runModel();
        logic [`MCPU_XLEN-1:0] regs [0:31];
        logic [`MCPU_XLEN-1:0] pc;
        logic [`MCPU_XLEN-1:0] nextPc;
        logic [`MCPU_XLEN-1:0] a;
        logic [`MCPU_XLEN-1:0] b;
        logic [`MCPU_XLEN-1:0] simm;
        logic [`MCPU_XLEN-1:0] ea;
        logic [31:0]           ins;
        logic                  endSeen;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            modelMem[i] = mem[i];
        end
        pc      = `MCPU_RESET_PC;
        endSeen = 1'b0;
        for (int n = 0; n < 2 * ProgLen; n++) begin
            expected.push_back(makeAccess(1'b0, pc, '0));
            if (pc == EndPc) begin
                if (endSeen) begin
                    break;
                end
                endSeen = 1'b1;
            end
            ins    = modelMem[pc[9:2]];
            a      = regs[ins[25:21]];
            b      = regs[ins[20:16]];
            simm   = {{16{ins[15]}}, ins[15:0]};
            ea     = a + simm;
            nextPc = pc + 32'd4;
            case (ins[31:26])
                `OP_RTYPE: begin
                    case (ins[5:0])
                        `FN_ADD: regs[ins[15:11]] = a + b;
                        `FN_SUB: regs[ins[15:11]] = a - b;
                        `FN_AND: regs[ins[15:11]] = a & b;
                        `FN_OR:  regs[ins[15:11]] = a | b;
                        default: regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                end
                `OP_ADDI: regs[ins[20:16]] = ea;
                `OP_ORI:  regs[ins[20:16]] = a | {16'h0000, ins[15:0]};
                `OP_LW: begin
                    expected.push_back(makeAccess(1'b0, ea, '0));
                    regs[ins[20:16]] = modelMem[ea[9:2]];
                end
                `OP_SW: begin
                    expected.push_back(makeAccess(1'b1, ea, b));
                    modelMem[ea[9:2]] = b;
                end
                `OP_BEQ: begin
                    if (a == b) begin
                        nextPc = nextPc + {simm[29:0], 2'b00};
                    end
                end
                `OP_BNE: begin
                    if (a != b) begin
                        nextPc = nextPc + {simm[29:0], 2'b00};
                    end
                end
                `OP_J: nextPc = {nextPc[31:28], ins[25:0], 2'b00};
                `OP_JAL: begin
                    regs[31] = nextPc;
                    nextPc   = {nextPc[31:28], ins[25:0], 2'b00};
                end
                default: ;
            endcase
            regs[0] = '0;
            pc      = nextPc;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory model with random wait states

    initial begin : memoryModel
        accessT                want;
        logic [`MCPU_XLEN-1:0] curAddr;
        logic [`MCPU_XLEN-1:0] curWData;
        logic                  curWrite;
        logic                  busy;
        logic                  tracked;
        logic                  firstCycle;
        int                    waitLeft;
        busy       = 1'b0;
        tracked    = 1'b0;
        firstCycle = 1'b1;
        waitLeft   = 0;
        wait (rstN === 1'b1);
        forever begin
            @(posedge clk);
            #1;
            if (firstCycle && (memRead !== 1'b1)) begin
                stopWithFailure("No fetch was issued in the first cycle after reset");
            end
            firstCycle = 1'b0;
            // Ready was high through this edge, so the access completed
            if (busy && memReady) begin
                if (curWrite) begin
                    mem[curAddr[9:2]] = curWData;
                end
                busy     = 1'b0;
                memReady = 1'b0;
                if (tracked && (expected.size() == 0)) begin
                    finished = 1'b1;
                end
            end
            if (busy) begin
                // Pending access must hold still
                if ((memRead !== !curWrite) || (memWrite !== curWrite)) begin
                    stopWithFailure("A memory strobe changed while its access was pending");
                end
                if (curWrite) begin
                    checkStore(memAddr, memWData, curAddr, curWData);
                end else begin
                    checkAddr(memAddr, curAddr, "pending read");
                end
            end else if (memRead || memWrite) begin
                curAddr  = memAddr;
                curWData = memWData;
                curWrite = memWrite;
                busy     = 1'b1;
                waitLeft = int'(drawRandom() & 32'd3);
                tracked  = (expected.size() > 0);
                if (tracked) begin
                    want = expected.pop_front();
                    if (want.isWrite !== memWrite) begin
                        stopWithFailure($sformatf("Mismatch at %0t: access kind at %h is wrong",
                                                  $time, memAddr));
                    end
                    if (want.isWrite) begin
                        checkStore(memAddr, memWData, want.addr, want.data);
                    end else begin
                        checkAddr(memAddr, want.addr, "read");
                    end
                end
            end
            if (busy) begin
                if (waitLeft == 0) begin
                    memReady = 1'b1;
                    memRData = curWrite ? '0 : mem[curAddr[9:2]];
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    initial begin : watchdog
        #(TimeoutNs);
        stopWithFailure("Timeout: the program never reached its final jump");
    end

    initial begin
        rstN     = 1'b0;
        memRData = '0;
        memReady = 1'b0;
        finished = 1'b0;
        rngState = 32'h48634632;
        buildProgram();
        runModel();
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        wait (finished);
        repeat (2) @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
